/* design/mem_wb_pkg.sv */
`default_nettype none

package mem_wb_pkg;

	// data and address width
	localparam int xlen = 64;
	// register index
	localparam int reg_addr_w = 5;
	localparam int num_regs = 32;
	// byte lanes per memory word
	localparam int lane_count = 8;
	localparam int offset_w = 3;

	// access width, log2 of the byte count
	typedef enum logic [1:0] {
		size_b = 2'd0,
		size_h = 2'd1,
		size_w = 2'd2,
		size_d = 2'd3
	} access_size_t;

	// none means an already computed result
	typedef enum logic [1:0] {
		kind_none  = 2'd0,
		kind_load  = 2'd1,
		kind_store = 2'd2
	} req_kind_t;

	// one memory word, seen at each access width
	typedef union packed {
		logic [lane_count-1:0][7:0]    bytes;
		logic [lane_count/2-1:0][15:0] halves;
		logic [lane_count/4-1:0][31:0] words;
		logic [xlen-1:0]               dword;
	} mem_word_u;

	typedef struct packed {
		logic                  valid;
		req_kind_t             kind;
		access_size_t          size;
		logic                  is_signed;
		logic [xlen-1:0]       pc;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       addr;
		// store data, or result when kind is none
		logic [xlen-1:0]       data;
	} mem_req_t;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [xlen-1:0]       paddr;
		logic [xlen-1:0]       pwdata;
		logic [lane_count-1:0] pstrb;
	} apb_req_t;

	typedef struct packed {
		logic            pready;
		logic [xlen-1:0] prdata;
	} apb_rsp_t;

	typedef struct packed {
		logic                  valid;
		req_kind_t             kind;
		access_size_t          size;
		logic                  is_signed;
		logic [xlen-1:0]       pc;
		logic [reg_addr_w-1:0] rd;
		logic [offset_w-1:0]   offset;
		// raw read word for loads
		logic [xlen-1:0]       data;
	} mem_done_t;

	typedef struct packed {
		logic                  valid;
		logic [xlen-1:0]       pc;
		logic [reg_addr_w-1:0] rd;
		logic                  wen;
		logic [xlen-1:0]       value;
	} commit_t;

endpackage

`default_nettype wire

/* design/store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module store_align (
	input  mem_wb_pkg::access_size_t               size,
	input  logic [mem_wb_pkg::offset_w-1:0]        offset,
	input  logic [mem_wb_pkg::xlen-1:0]            data,
	output mem_wb_pkg::mem_word_u                  lane_data,
	output logic [mem_wb_pkg::lane_count-1:0]      strobe
);

	// strobe and data before the shift by offset
	logic [mem_wb_pkg::lane_count-1:0] base_strobe;
	logic [mem_wb_pkg::xlen-1:0]       base_data;
	// offset bits that must be zero for this size
	logic [mem_wb_pkg::offset_w-1:0]   align_mask;

	always_comb begin
		// mask is byte count minus one
		case (size)
			mem_wb_pkg::size_b: begin
				base_strobe = 8'h01;
				align_mask = 3'b000;
			end
			mem_wb_pkg::size_h: begin
				base_strobe = 8'h03;
				align_mask = 3'b001;
			end
			mem_wb_pkg::size_w: begin
				base_strobe = 8'h0f;
				align_mask = 3'b011;
			end
			default: begin
				base_strobe = 8'hff;
				align_mask = 3'b111;
			end
		endcase
		// keep only the lanes the access covers
		for (int i = 0; i < mem_wb_pkg::lane_count; i++) begin
			base_data[i*8 +: 8] = base_strobe[i] ? data[i*8 +: 8] : 8'h00;
		end
	end

	// byte offset moves both strobe and data up
	assign strobe = base_strobe << offset;
	assign lane_data.dword = base_data << {offset, 3'b000};

	// access must not cross into the next word
	always_comb begin
		fits_word: assert final ((offset & align_mask) == '0)
			else $error("store_align: offset %0d not aligned to size %0d", offset, size);
	end

endmodule

`default_nettype wire

/* design/lsu_apb_master.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_apb_master (
	input  logic                  clk,
	input  logic                  rst,
	input  mem_wb_pkg::mem_req_t  req,
	input  mem_wb_pkg::apb_rsp_t  apb_in,
	output logic                  req_ready,
	output mem_wb_pkg::apb_req_t  apb_out,
	output mem_wb_pkg::mem_done_t done
);

	typedef enum logic [1:0] {
		st_idle   = 2'd0,
		st_setup  = 2'd1,
		st_access = 2'd2
	} state_t;

	state_t state;
	logic accept;
	logic req_mem;
	logic xfer_end;
	// request and lanes held for the whole transfer
	mem_wb_pkg::mem_req_t  hold;
	mem_wb_pkg::mem_word_u hold_lanes;
	logic [mem_wb_pkg::lane_count-1:0] hold_strb;
	// aligner outputs, sampled at acceptance
	mem_wb_pkg::mem_word_u lanes;
	logic [mem_wb_pkg::lane_count-1:0] strb;
	logic [mem_wb_pkg::offset_w-1:0] align_offset;

	assign req_ready = (state == st_idle);
	assign accept = req.valid && req_ready;
	assign req_mem = (req.kind == mem_wb_pkg::kind_load) || (req.kind == mem_wb_pkg::kind_store);
	// last access cycle of a transfer
	assign xfer_end = (state == st_access) && apb_in.pready;

	// offset only matters for a real memory request
	assign align_offset = (req.valid && req_mem) ? req.addr[mem_wb_pkg::offset_w-1:0] : '0;

	store_align u_store_align (
		.size      (req.size),
		.offset    (align_offset),
		.data      (req.data),
		.lane_data (lanes),
		.strobe    (strb)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:   if (accept && req_mem) state <= st_setup;
				st_setup:  state <= st_access;
				// slave may stall here
				st_access: if (apb_in.pready) state <= st_idle;
				default:   state <= st_idle;
			endcase
		end
	end

	// payload captured once per memory request
	always_ff @(posedge clk) begin
		if (accept && req_mem) begin
			hold <= req;
			hold_lanes <= lanes;
			hold_strb <= strb;
		end
	end

	always_comb begin
		apb_out.psel = (state != st_idle);
		apb_out.penable = (state == st_access);
		apb_out.pwrite = (hold.kind == mem_wb_pkg::kind_store);
		// word aligned, lanes picked by strobe or offset
		apb_out.paddr = {hold.addr[mem_wb_pkg::xlen-1:mem_wb_pkg::offset_w], 3'b000};
		apb_out.pwdata = hold_lanes.dword;
		// reads carry no strobe
		apb_out.pstrb = apb_out.pwrite ? hold_strb : '0;
	end

	always_comb begin
		done = '0;
		if (accept && !req_mem) begin
			// result bypasses the bus in the acceptance cycle
			done.valid = 1'b1;
			done.kind = req.kind;
			done.size = req.size;
			done.is_signed = req.is_signed;
			done.pc = req.pc;
			done.rd = req.rd;
			done.data = req.data;
		end else if (xfer_end) begin
			done.valid = 1'b1;
			done.kind = hold.kind;
			done.size = hold.size;
			done.is_signed = hold.is_signed;
			done.pc = hold.pc;
			done.rd = hold.rd;
			done.offset = hold.addr[mem_wb_pkg::offset_w-1:0];
			// stores report the data they wrote
			done.data = (hold.kind == mem_wb_pkg::kind_load) ? apb_in.prdata : hold.data;
		end
	end

	penable_needs_psel: assert property (@(posedge clk) disable iff (rst)
		apb_out.penable |-> apb_out.psel);

	// address, control and data hold until the slave completes
	apb_stable: assert property (@(posedge clk) disable iff (rst)
		(apb_out.psel && !(apb_out.penable && apb_in.pready)) |=>
		(apb_out.psel && $stable({apb_out.paddr, apb_out.pwrite, apb_out.pwdata, apb_out.pstrb})));

endmodule

`default_nettype wire

/* design/writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
	input  logic                              clk,
	input  logic                              rst,
	input  mem_wb_pkg::mem_done_t             done,
	output logic                              wen,
	output logic [mem_wb_pkg::reg_addr_w-1:0] waddr,
	output logic [mem_wb_pkg::xlen-1:0]       wdata,
	output mem_wb_pkg::commit_t               commit
);

	mem_wb_pkg::mem_word_u rd_word;
	// lanes selected by offset at each width
	logic [7:0]  b_lane;
	logic [15:0] h_lane;
	logic [31:0] w_lane;
	logic [mem_wb_pkg::xlen-1:0] load_val;
	logic [mem_wb_pkg::xlen-1:0] result;
	// output register
	logic                              valid_q;
	logic                              wen_q;
	logic [mem_wb_pkg::xlen-1:0]       pc_q;
	logic [mem_wb_pkg::reg_addr_w-1:0] rd_q;
	logic [mem_wb_pkg::xlen-1:0]       value_q;

	assign rd_word = done.data;
	assign b_lane = rd_word.bytes[done.offset];
	// upper offset bits pick the half or word
	assign h_lane = rd_word.halves[done.offset[2:1]];
	assign w_lane = rd_word.words[done.offset[2]];

	always_comb begin
		case (done.size)
			mem_wb_pkg::size_b: load_val = {{56{done.is_signed & b_lane[7]}}, b_lane};
			mem_wb_pkg::size_h: load_val = {{48{done.is_signed & h_lane[15]}}, h_lane};
			mem_wb_pkg::size_w: load_val = {{32{done.is_signed & w_lane[31]}}, w_lane};
			default:            load_val = rd_word.dword;
		endcase
	end

	// non-memory results and store data pass unchanged
	assign result = (done.kind == mem_wb_pkg::kind_load) ? load_val : done.data;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
			wen_q <= 1'b0;
		end else begin
			valid_q <= done.valid;
			// stores only commit
			wen_q <= done.valid && (done.kind != mem_wb_pkg::kind_store);
		end
	end

	always_ff @(posedge clk) begin
		if (done.valid) begin
			pc_q <= done.pc;
			rd_q <= done.rd;
			value_q <= result;
		end
	end

	// register write port
	assign wen = wen_q;
	assign waddr = rd_q;
	assign wdata = value_q;

	// commit record
	assign commit.valid = valid_q;
	assign commit.pc = pc_q;
	assign commit.rd = rd_q;
	assign commit.wen = wen_q;
	assign commit.value = value_q;

endmodule

`default_nettype wire

/* design/gpr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr_file (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              wen,
	input  logic [mem_wb_pkg::reg_addr_w-1:0] waddr,
	input  logic [mem_wb_pkg::xlen-1:0]       wdata,
	input  logic [mem_wb_pkg::reg_addr_w-1:0] raddr,
	output logic [mem_wb_pkg::xlen-1:0]       rdata
);

	logic [mem_wb_pkg::xlen-1:0] regs [mem_wb_pkg::num_regs];

	always_ff @(posedge clk) begin
		if (rst) begin
			// all registers start at zero
			for (int i = 0; i < mem_wb_pkg::num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (waddr != '0)) begin
			// x0 is never written
			regs[waddr] <= wdata;
		end
	end

	// x0 reads zero regardless of array contents
	assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

`default_nettype wire

/* design/mem_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top (
	input  logic                              clk,
	input  logic                              rst,
	input  mem_wb_pkg::mem_req_t              req,
	input  mem_wb_pkg::apb_rsp_t              apb_in,
	input  logic [mem_wb_pkg::reg_addr_w-1:0] raddr,
	output logic                              req_ready,
	output mem_wb_pkg::apb_req_t              apb_out,
	output logic [mem_wb_pkg::xlen-1:0]       rdata,
	output mem_wb_pkg::commit_t               commit
);

	// completion from bus master to write-back
	mem_wb_pkg::mem_done_t done;
	// register write path
	logic                              wen;
	logic [mem_wb_pkg::reg_addr_w-1:0] waddr;
	logic [mem_wb_pkg::xlen-1:0]       wdata;

	lsu_apb_master u_lsu (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.apb_in    (apb_in),
		.req_ready (req_ready),
		.apb_out   (apb_out),
		.done      (done)
	);

	writeback_stage u_wb (
		.clk    (clk),
		.rst    (rst),
		.done   (done),
		.wen    (wen),
		.waddr  (waddr),
		.wdata  (wdata),
		.commit (commit)
	);

	gpr_file u_gpr (
		.clk   (clk),
		.rst   (rst),
		.wen   (wen),
		.waddr (waddr),
		.wdata (wdata),
		.raddr (raddr),
		.rdata (rdata)
	);

endmodule

`default_nettype wire

/* dv/tb_mem_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_wb;

	localparam int clk_period = 4;
	localparam int drive_delay = 1;
	localparam int wait_limit = 64;
	localparam int mem_words = 64;
	localparam logic [31:0] seed = 32'h8edf_e918;

	logic clk;
	logic rst;
	mem_wb_pkg::mem_req_t req;
	mem_wb_pkg::apb_rsp_t apb_in;
	logic [mem_wb_pkg::reg_addr_w-1:0] raddr;
	logic req_ready;
	mem_wb_pkg::apb_req_t apb_out;
	logic [mem_wb_pkg::xlen-1:0] rdata;
	mem_wb_pkg::commit_t commit;

	// slave model memory, indexed by paddr[8:3]
	logic [63:0] mem [mem_words];
	int unsigned wait_left;
	// addr, write, data, strobe as seen in setup
	logic [136:0] setup_snap;
	// last completed access phase
	logic [7:0] seen_strb;
	logic [63:0] seen_wdata;
	logic [63:0] seen_addr;
	logic seen_write;
	// commits in arrival order
	mem_wb_pkg::commit_t commits [$];
	logic mem_busy;

	mem_wb_top dut0 (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.apb_in    (apb_in),
		.raddr     (raddr),
		.req_ready (req_ready),
		.apb_out   (apb_out),
		.rdata     (rdata),
		.commit    (commit)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
		end
	endtask

	// lowest 1, 2, 4 or 8 byte lanes
	function automatic logic [7:0] lane_mask(input mem_wb_pkg::access_size_t sz);
		case (sz)
			mem_wb_pkg::size_b: return 8'h01;
			mem_wb_pkg::size_h: return 8'h03;
			mem_wb_pkg::size_w: return 8'h0f;
			default:            return 8'hff;
		endcase
	endfunction

	// byte strobe widened to a bit mask
	function automatic logic [63:0] lanes_to_bits(input logic [7:0] strb);
		logic [63:0] bits;
		for (int i = 0; i < 8; i++) begin
			bits[i*8 +: 8] = {8{strb[i]}};
		end
		return bits;
	endfunction

	function automatic logic [63:0] load_expect(input logic [63:0] word,
			input mem_wb_pkg::access_size_t sz, input logic [2:0] off, input logic sgn);
		logic [63:0] keep;
		logic [63:0] raw;
		keep = lanes_to_bits(lane_mask(sz));
		raw = (word >> {off, 3'b000}) & keep;
		// top kept bit decides the fill
		if (sgn && ((raw & ~(keep >> 1)) != 64'h0)) begin
			raw = raw | ~keep;
		end
		return raw;
	endfunction

	// APB slave, 0 to 3 wait states per transfer
	initial begin
		apb_in = '0;
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = 64'h0123_4567_89ab_cdef ^ {8{2'b10, 6'(i)}};
		end
		forever begin
			@(posedge clk);
			#drive_delay;
			apb_in.pready = 1'b0;
			apb_in.prdata = '0;
			if (apb_out.psel && !apb_out.penable) begin
				setup_snap = {apb_out.paddr, apb_out.pwrite, apb_out.pwdata, apb_out.pstrb};
				wait_left = $urandom_range(3, 0);
			end else if (apb_out.psel) begin
				if (setup_snap !== {apb_out.paddr, apb_out.pwrite, apb_out.pwdata, apb_out.pstrb}) begin
					abort_run("APB address or data changed before the transfer ended");
				end
				if (wait_left == 0) begin
					apb_in.pready = 1'b1;
					seen_strb = apb_out.pstrb;
					seen_wdata = apb_out.pwdata;
					seen_addr = apb_out.paddr;
					seen_write = apb_out.pwrite;
					if (apb_out.pwrite) begin
						for (int i = 0; i < 8; i++) begin
							if (apb_out.pstrb[i]) begin
								mem[apb_out.paddr[8:3]][i*8 +: 8] = apb_out.pwdata[i*8 +: 8];
							end
						end
					end else begin
						apb_in.prdata = mem[apb_out.paddr[8:3]];
					end
				end else begin
					wait_left--;
				end
			end
		end
	end

	// commit monitor, also tracks req_ready over a memory access
	initial begin
		mem_busy = 1'b0;
		forever begin
			@(negedge clk);
			if (!rst) begin
				if (commit.valid === 1'b1) begin
					commits.push_back(commit);
					if (req_ready !== 1'b1) begin
						abort_run("req_ready was low in a commit cycle");
					end
					mem_busy = 1'b0;
				end else if (mem_busy && req_ready !== 1'b0) begin
					abort_run("req_ready rose before the memory access finished");
				end
				// acceptance happens at the coming edge
				if (req.valid && req_ready === 1'b1 && req.kind != mem_wb_pkg::kind_none) begin
					mem_busy = 1'b1;
				end
			end
		end
	end

	task automatic issue(input mem_wb_pkg::req_kind_t op_kind,
			input mem_wb_pkg::access_size_t op_size, input logic sgn, input logic [63:0] pc,
			input logic [4:0] rd, input logic [63:0] addr, input logic [63:0] data);
		int n;
		n = 0;
		req = '{valid: 1'b1, kind: op_kind, size: op_size, is_signed: sgn,
			pc: pc, rd: rd, addr: addr, data: data};
		while (req_ready !== 1'b1) begin
			n++;
			if (n > wait_limit) begin
				abort_run("request was never accepted, req_ready stayed low");
			end
			@(posedge clk);
			#drive_delay;
		end
		@(posedge clk);
		#drive_delay;
		req.valid = 1'b0;
	endtask

	task automatic wait_commit(output mem_wb_pkg::commit_t c);
		int n;
		n = 0;
		while (commits.size() == 0) begin
			n++;
			if (n > wait_limit) begin
				abort_run("no commit arrived for an issued request");
			end
			@(posedge clk);
			#drive_delay;
		end
		c = commits.pop_front();
	endtask

	// rdata sampled mid-cycle, then back to the drive point
	task automatic read_reg(input string name, input logic [4:0] idx, input logic [63:0] exp);
		raddr = idx;
		@(negedge clk);
		check_equal(name, exp, rdata);
		@(posedge clk);
		#drive_delay;
	endtask

	task automatic test_reset();
		check_equal("reset_ready", 64'h1, 64'(req_ready));
		check_equal("reset_psel", 64'h0, 64'(apb_out.psel));
		check_equal("reset_commit", 64'h0, 64'(commit.valid));
		read_reg("reset_x0", 5'd0, 64'h0);
		read_reg("reset_x5", 5'd5, 64'h0);
		read_reg("reset_x31", 5'd31, 64'h0);
	endtask

	task automatic test_alu();
		mem_wb_pkg::commit_t c;
		issue(mem_wb_pkg::kind_none, mem_wb_pkg::size_d, 1'b0, 64'h1000, 5'd5, 64'h0,
			64'hdead_beef_1234_5678);
		wait_commit(c);
		check_equal("alu_pc", 64'h1000, c.pc);
		check_equal("alu_rd", 64'd5, 64'(c.rd));
		check_equal("alu_wen", 64'h1, 64'(c.wen));
		check_equal("alu_value", 64'hdead_beef_1234_5678, c.value);
		read_reg("alu_x5", 5'd5, 64'hdead_beef_1234_5678);
		// x0 commits but keeps zero
		issue(mem_wb_pkg::kind_none, mem_wb_pkg::size_d, 1'b0, 64'h1004, 5'd0, 64'h0, '1);
		wait_commit(c);
		check_equal("alu_x0_wen", 64'h1, 64'(c.wen));
		read_reg("alu_x0", 5'd0, 64'h0);
	endtask

	task automatic test_stores();
		mem_wb_pkg::commit_t c;
		mem_wb_pkg::access_size_t sz;
		logic [63:0] data;
		logic [63:0] old;
		logic [7:0] strb;
		logic [63:0] lanes;
		int word;
		for (int s = 0; s < 4; s++) begin
			for (int off = 0; off < 8; off += (1 << s)) begin
				sz = mem_wb_pkg::access_size_t'(s);
				word = 8 + s * 8 + off;
				data = {$urandom, $urandom};
				// alternate the sign bit of every lane width
				if (((off >> s) % 2) == 0) begin
					data = data | 64'h8080_8080_8080_8080;
				end else begin
					data = data & ~64'h8080_8080_8080_8080;
				end
				old = mem[word];
				strb = lane_mask(sz) << off;
				lanes = (data << {3'(off), 3'b000}) & lanes_to_bits(strb);
				issue(mem_wb_pkg::kind_store, sz, 1'b0, 64'(32'h2000 + word), 5'd3,
					64'(word * 8 + off), data);
				wait_commit(c);
				check_equal("store_pc", 64'(32'h2000 + word), c.pc);
				check_equal("store_wen", 64'h0, 64'(c.wen));
				check_equal("store_pwrite", 64'h1, 64'(seen_write));
				check_equal("store_paddr", 64'(word * 8), seen_addr);
				check_equal("store_pstrb", 64'(strb), 64'(seen_strb));
				check_equal("store_lanes", lanes, seen_wdata & lanes_to_bits(strb));
				check_equal("store_mem", (old & ~lanes_to_bits(strb)) | lanes, mem[word]);
			end
		end
	endtask

	task automatic test_loads();
		mem_wb_pkg::commit_t c;
		mem_wb_pkg::access_size_t sz;
		logic [63:0] exp;
		logic [4:0] rd;
		int word;
		for (int s = 0; s < 4; s++) begin
			for (int off = 0; off < 8; off += (1 << s)) begin
				for (int sgn = 0; sgn < 2; sgn++) begin
					sz = mem_wb_pkg::access_size_t'(s);
					word = 8 + s * 8 + off;
					rd = 5'(1 + s * 8 + off);
					exp = load_expect(mem[word], sz, 3'(off), 1'(sgn));
					issue(mem_wb_pkg::kind_load, sz, 1'(sgn), 64'(32'h4000 + word), rd,
						64'(word * 8 + off), 64'h0);
					wait_commit(c);
					check_equal("load_pwrite", 64'h0, 64'(seen_write));
					check_equal("load_rd", 64'(rd), 64'(c.rd));
					check_equal("load_wen", 64'h1, 64'(c.wen));
					check_equal("load_value", exp, c.value);
					read_reg("load_reg", rd, exp);
				end
			end
		end
	endtask

	// mixed back-to-back requests, commits must keep issue order
	task automatic test_burst();
		mem_wb_pkg::commit_t c;
		logic [63:0] pcs [8];
		logic [63:0] vals [8];
		logic wens [8];
		for (int i = 0; i < 8; i++) begin
			pcs[i] = 64'h3000 + 64'(i * 4);
			case (i % 3)
				0: begin
					vals[i] = 64'hc0ff_ee00_0000_0000 + 64'(i);
					wens[i] = 1'b1;
					issue(mem_wb_pkg::kind_none, mem_wb_pkg::size_d, 1'b0, pcs[i], 5'd10,
						64'h0, vals[i]);
				end
				1: begin
					vals[i] = mem[8];
					wens[i] = 1'b1;
					issue(mem_wb_pkg::kind_load, mem_wb_pkg::size_d, 1'b0, pcs[i], 5'd12,
						64'd64, 64'h0);
				end
				default: begin
					vals[i] = 64'h0;
					wens[i] = 1'b0;
					issue(mem_wb_pkg::kind_store, mem_wb_pkg::size_d, 1'b0, pcs[i], 5'd0,
						64'd400, {$urandom, $urandom});
				end
			endcase
		end
		for (int i = 0; i < 8; i++) begin
			wait_commit(c);
			check_equal("burst_pc", pcs[i], c.pc);
			check_equal("burst_wen", 64'(wens[i]), 64'(c.wen));
			if (wens[i]) begin
				check_equal("burst_value", vals[i], c.value);
			end
		end
	endtask

	initial begin
		void'($urandom(seed));
		rst = 1'b1;
		req = '0;
		raddr = '0;
		repeat (2) @(posedge clk);
		#drive_delay;
		rst = 1'b0;
		test_reset();
		test_alu();
		test_stores();
		test_loads();
		test_burst();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
design/mem_wb_pkg.sv
design/store_align.sv
design/lsu_apb_master.sv
design/writeback_stage.sv
design/gpr_file.sv
design/mem_wb_top.sv
dv/tb_mem_wb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_mem_wb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
